/* compile.f */
hw/dds_pkg.sv
hw/stream_pkg.sv
hw/dds_cos_lut.sv
hw/dds_phase_accumulator.sv
hw/dds_channel.sv
hw/dds_multichannel.sv
testbench/dds_multichannel_tb.sv

/* hw/dds_channel.sv */
/* One DDS channel as a three-stage pipeline (phase, ROM, output) that stalls as a whole
   when the output beat is held. Three beats can be in flight, so increment changes lag. */
module dds_channel #(
  parameter int PARALLEL_SAMPLES = 4,
  parameter int LUT_ADDR_BITS = 10
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     inc_valid,
  input  dds_pkg::phase_t          inc,
  output stream_pkg::sample_beat_t sample_out,
  input  logic                     ready
);

  if (PARALLEL_SAMPLES < 1 || PARALLEL_SAMPLES > stream_pkg::MAX_PARALLEL) begin : g_bad_lanes
    $error("PARALLEL_SAMPLES must lie between 1 and MAX_PARALLEL");
  end

  // single enable for every stage
  logic advance;

  // stage 1, phases of one beat
  dds_pkg::phase_t [stream_pkg::MAX_PARALLEL-1:0]  s1_phases;
  logic                                            s1_valid;

  // stage 2, ROM samples
  dds_pkg::sample_t [stream_pkg::MAX_PARALLEL-1:0] s2_samples;
  logic                                            s2_valid;

  // stage 3, output register
  dds_pkg::sample_t [stream_pkg::MAX_PARALLEL-1:0] out_data;
  logic                                            out_valid;

  // move only when the output slot is free or being taken
  assign advance = !out_valid || ready;

  dds_phase_accumulator #(
    .PARALLEL_SAMPLES(PARALLEL_SAMPLES)
  ) i_accumulator (
    .clk,
    .reset,
    .advance,
    .inc_valid,
    .inc,
    .phases       (s1_phases),
    .phases_valid (s1_valid)
  );

  dds_cos_lut #(
    .PARALLEL_SAMPLES(PARALLEL_SAMPLES),
    .LUT_ADDR_BITS(LUT_ADDR_BITS)
  ) i_lut (
    .clk,
    .enable  (advance),
    .phases  (s1_phases),
    .samples (s2_samples)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      s2_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else if (advance) begin
      s2_valid  <= s1_valid;
      out_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      out_data <= s2_samples;
    end
  end

  assign sample_out = '{valid: out_valid, data: out_data};

  // a held beat keeps its data until it is taken
  a_hold_stable: assert property (@(posedge clk) disable iff (reset)
    out_valid && !ready |=> out_valid && $stable(out_data));

  // nothing leaves right after a reset cycle
  a_reset_clears: assert property (@(posedge clk)
    reset |=> !sample_out.valid);

endmodule

/* hw/dds_cos_lut.sv */
/* Full-wave cosine ROM with one registered read port per lane, 2**LUT_ADDR_BITS deep.
   The phase is truncated to its top bits; lanes past PARALLEL_SAMPLES read as zero. */
module dds_cos_lut #(
  parameter int PARALLEL_SAMPLES = 4,
  parameter int LUT_ADDR_BITS = 10
) (
  input  logic                                            clk,
  input  logic                                            enable,
  input  dds_pkg::phase_t [stream_pkg::MAX_PARALLEL-1:0]  phases,
  output dds_pkg::sample_t [stream_pkg::MAX_PARALLEL-1:0] samples
);

  localparam int LUT_DEPTH = 2 ** LUT_ADDR_BITS;

  typedef dds_pkg::sample_t table_t [LUT_DEPTH];

  if (LUT_ADDR_BITS < 1 || LUT_ADDR_BITS > dds_pkg::PHASE_BITS) begin : g_bad_addr_bits
    $error("LUT_ADDR_BITS must lie between 1 and PHASE_BITS");
  end

  // AMPLITUDE * cos(2*pi*a/LUT_DEPTH) rounded to nearest by the int cast
  function automatic table_t cos_table();
    table_t t;
    real    angle;
    for (int a = 0; a < LUT_DEPTH; a++) begin
      angle = 2.0 * dds_pkg::PI * real'(a) / real'(LUT_DEPTH);
      t[a] = dds_pkg::sample_t'(int'(real'(dds_pkg::AMPLITUDE) * $cos(angle)));
    end
    return t;
  endfunction

  table_t rom = cos_table();

  logic [LUT_ADDR_BITS-1:0] addr [stream_pkg::MAX_PARALLEL];

  always_comb begin
    for (int k = 0; k < stream_pkg::MAX_PARALLEL; k++) begin
      addr[k] = phases[k][dds_pkg::PHASE_BITS-1 -: LUT_ADDR_BITS];
    end
  end

  // all lanes hold while enable is low
  always_ff @(posedge clk) begin
    if (enable) begin
      for (int k = 0; k < stream_pkg::MAX_PARALLEL; k++) begin
        if (k < PARALLEL_SAMPLES) begin
          samples[k] <= rom[addr[k]];
        end else begin
          samples[k] <= '0;
        end
      end
    end
  end

endmodule

/* hw/dds_multichannel.sv */
/* Multichannel DDS. One increment beat loads all channels at once and has no ready;
   each channel streams its own samples and stalls independently of the others. */
module dds_multichannel #(
  parameter int CHANNELS = 2,
  parameter int PARALLEL_SAMPLES = 4,
  parameter int LUT_ADDR_BITS = 10
) (
  input  logic                     clk,
  input  logic                     reset,
  input  stream_pkg::inc_beat_t    phase_inc_in,
  output stream_pkg::sample_beat_t data_out [CHANNELS],
  input  logic [CHANNELS-1:0]      data_ready
);

  if (CHANNELS < 1 || CHANNELS > stream_pkg::MAX_CHANNELS) begin : g_bad_channels
    $error("CHANNELS must lie between 1 and MAX_CHANNELS");
  end

  // entries of phase_inc_in above CHANNELS are left unconnected
  for (genvar c = 0; c < CHANNELS; c++) begin : g_channel
    dds_channel #(
      .PARALLEL_SAMPLES(PARALLEL_SAMPLES),
      .LUT_ADDR_BITS(LUT_ADDR_BITS)
    ) i_channel (
      .clk,
      .reset,
      .inc_valid  (phase_inc_in.valid),
      .inc        (phase_inc_in.inc[c]),
      .sample_out (data_out[c]),
      .ready      (data_ready[c])
    );
  end

endmodule

/* hw/dds_phase_accumulator.sv */
/* Phase accumulator of one channel. Each advance registers PARALLEL_SAMPLES phases
   base + k*inc and moves the base by PARALLEL_SAMPLES*inc, wrapping modulo 2**PHASE_BITS. */
module dds_phase_accumulator #(
  parameter int PARALLEL_SAMPLES = 4
) (
  input  logic                                           clk,
  input  logic                                           reset,
  input  logic                                           advance,
  input  logic                                           inc_valid,
  input  dds_pkg::phase_t                                inc,
  output dds_pkg::phase_t [stream_pkg::MAX_PARALLEL-1:0] phases,
  output logic                                           phases_valid
);

  // increment in use
  // a write only reaches beats formed after it
  dds_pkg::phase_t inc_q;

  // phase of lane 0 of the next beat
  dds_pkg::phase_t base;

  dds_pkg::phase_t                                base_next;
  dds_pkg::phase_t [stream_pkg::MAX_PARALLEL-1:0] phases_next;

  // running sum instead of k*inc, ends up one beat ahead of base
  always_comb begin
    base_next = base;
    for (int k = 0; k < stream_pkg::MAX_PARALLEL; k++) begin
      if (k < PARALLEL_SAMPLES) begin
        phases_next[k] = base_next;
        base_next = base_next + inc_q;
      end else begin
        phases_next[k] = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      inc_q        <= '0;
      base         <= '0;
      phases_valid <= 1'b0;
    end else begin
      if (inc_valid) begin
        inc_q <= inc;
      end
      if (advance) begin
        base         <= base_next;
        phases_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      phases <= phases_next;
    end
  end

endmodule

/* hw/dds_pkg.sv */
/* Number formats shared by the synthesizer. Phase words wrap modulo 2**PHASE_BITS
   and samples are signed two's complement at full scale +/-AMPLITUDE. */
package dds_pkg;

  // phase accumulator width
  // one lsb of phase is 2**-PHASE_BITS of a cycle
  localparam int PHASE_BITS = 24;

  // output sample width
  localparam int SAMPLE_WIDTH = 16;

  // largest positive sample so that +1.0 and -1.0 both map without overflow
  localparam int AMPLITUDE = 2 ** (SAMPLE_WIDTH - 1) - 1;

  // used when the cosine table is built
  localparam real PI = 3.14159265358979323846;

  // unsigned phase word
  // the per-channel frequency control word uses the same format
  typedef logic [PHASE_BITS-1:0] phase_t;

  // signed output sample
  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

endpackage

/* hw/stream_pkg.sv */
/* Beat formats of the increment input and of the per-channel sample outputs.
   Entries above the configured channel or lane count are ignored on input, zero on output. */
package stream_pkg;

  // upper bounds for the CHANNELS and PARALLEL_SAMPLES module parameters
  localparam int MAX_CHANNELS = 4;
  localparam int MAX_PARALLEL = 8;

  // one increment per channel, channel 0 in the low bits
  typedef struct packed {
    logic                                 valid;
    dds_pkg::phase_t [MAX_CHANNELS-1:0]   inc;
  } inc_beat_t;

  // consecutive samples of one channel
  // entry 0 is the earliest in time
  typedef struct packed {
    logic                                 valid;
    dds_pkg::sample_t [MAX_PARALLEL-1:0]  data;
  } sample_beat_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the DDS testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=dds_multichannel_tb

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module "$TOP" -Mdir "$BUILD_DIR" -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG_FILE"; then
  echo "result: PASS"
  exit 0
else
  echo "result: FAIL"
  exit 1
fi

/* testbench/dds_multichannel_tb.sv */
/* Testbench for the multichannel DDS with its default parameters (2 channels, 4 lanes).
   The stimulus table holds two increments per row, so it covers channels 0 and 1 only. */
module dds_multichannel_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CHANNELS = 2;
  localparam int PARALLEL_SAMPLES = 4;
  localparam int LUT_ADDR_BITS = 10;
  localparam int NUM_ROWS = 6;
  localparam int ADDR_SHIFT = dds_pkg::PHASE_BITS - LUT_ADDR_BITS;

  localparam logic [1:0] READY_ALWAYS = 2'd0;
  localparam logic [1:0] READY_RANDOM = 2'd1;
  localparam logic [1:0] READY_CH1_LOW = 2'd2;

  typedef struct packed {
    dds_pkg::phase_t inc0;
    dds_pkg::phase_t inc1;
    logic [1:0]      mode;
    logic [15:0]     beats;
  } row_t;

  // large and near-half-cycle increments make the phase wrap often
  row_t rows [NUM_ROWS] = '{
    '{24'h010000, 24'h004000, READY_ALWAYS,  16'd12},
    '{24'h123457, 24'hFEDCBA, READY_ALWAYS,  16'd16},
    '{24'h0A0B0C, 24'h3C0F01, READY_RANDOM,  16'd40},
    '{24'h001234, 24'h2AAAAB, READY_CH1_LOW, 16'd20},
    '{24'h7FFFFF, 24'h055555, READY_RANDOM,  16'd24},
    '{24'h800000, 24'h000001, READY_ALWAYS,  16'd10}
  };

  logic                     clk;
  logic                     reset;
  stream_pkg::inc_beat_t    phase_inc_in;
  stream_pkg::sample_beat_t data_out [CHANNELS];
  logic [CHANNELS-1:0]      data_ready;

  // ready control, only touched by the main sequence
  logic [1:0]  ready_mode;
  logic        stall_all;
  int unsigned lcg_state = 32'd66;

  // reference model, one entry per channel
  dds_pkg::phase_t model_phase [CHANNELS];
  dds_pkg::phase_t model_inc [CHANNELS];
  dds_pkg::phase_t model_next_inc [CHANNELS];
  int              old_steps [CHANNELS];

  // monitor state
  int   beats_got [CHANNELS];
  logic seen_valid [CHANNELS];
  logic held [CHANNELS];
  dds_pkg::sample_t [stream_pkg::MAX_PARALLEL-1:0] held_data [CHANNELS];

  int sample_errors;
  int valid_errors;
  int hold_errors;
  int cycle_count;

  dds_multichannel #(
    .CHANNELS(CHANNELS),
    .PARALLEL_SAMPLES(PARALLEL_SAMPLES),
    .LUT_ADDR_BITS(LUT_ADDR_BITS)
  ) i_dut (
    .clk,
    .reset,
    .phase_inc_in,
    .data_out,
    .data_ready
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic int unsigned lcg_next(int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // table value for the top LUT_ADDR_BITS of the phase, rounded to nearest
  function automatic int expected_cos(dds_pkg::phase_t phase);
    int unsigned addr;
    real         angle;
    real         v;
    addr = 32'(phase) >> ADDR_SHIFT;
    angle = 2.0 * dds_pkg::PI * real'(addr) / real'(2 ** LUT_ADDR_BITS);
    v = real'(dds_pkg::AMPLITUDE) * $cos(angle);
    return $rtoi($floor(v + 0.5));
  endfunction

  function automatic int timeout_cycles();
    int sum;
    sum = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      sum += int'(rows[r].beats);
    end
    return 2 * sum + 6 * NUM_ROWS + 50;
  endfunction

  // the 3 beats in flight keep the old increment for 3*PARALLEL_SAMPLES steps;
  // a write before any of those steps was taken just replaces the pending value
  task automatic model_write(int c, dds_pkg::phase_t inc);
    model_next_inc[c] = inc;
    if (old_steps[c] == 0) begin
      old_steps[c] = 3 * PARALLEL_SAMPLES;
    end
  endtask

  task automatic model_step(int c);
    model_phase[c] = model_phase[c] + model_inc[c];
    if (old_steps[c] > 0) begin
      old_steps[c]--;
      if (old_steps[c] == 0) begin
        model_inc[c] = model_next_inc[c];
      end
    end
  endtask

  task automatic check_beat(int c, stream_pkg::sample_beat_t beat);
    int expected;
    int actual;
    int diff;
    for (int k = 0; k < stream_pkg::MAX_PARALLEL; k++) begin
      actual = int'(beat.data[k]);
      if (k < PARALLEL_SAMPLES) begin
        expected = expected_cos(model_phase[c]);
        model_step(c);
      end else begin
        // unused lanes
        expected = 0;
      end
      diff = actual - expected;
      a_sample: assert (diff >= -1 && diff <= 1) else begin
        $display("[FAIL] %0t: channel %0d lane %0d expected %0d, got %0d",
                 $time, c, k, expected, actual);
        sample_errors++;
      end
    end
  endtask

  task automatic drive_ready();
    logic [CHANNELS-1:0] r;
    r = '1;
    if (stall_all) begin
      r = '0;
    end else if (ready_mode == READY_RANDOM) begin
      for (int c = 0; c < CHANNELS; c++) begin
        lcg_state = lcg_next(lcg_state);
        r[c] = lcg_state[16] | lcg_state[17];
      end
    end else if (ready_mode == READY_CH1_LOW) begin
      r[1] = 1'b0;
    end
    data_ready <= r;
  endtask

  // one clock edge: outputs and data_ready still hold their pre-edge values here
  task automatic step_cycle();
    stream_pkg::sample_beat_t beat;
    @(posedge clk);
    for (int c = 0; c < CHANNELS; c++) begin
      beat = data_out[c];
      seen_valid[c] = beat.valid;
      if (held[c]) begin
        a_hold: assert (beat.valid === 1'b1 && beat.data == held_data[c]) else begin
          $display("[FAIL] %0t: channel %0d changed a beat that was not accepted",
                   $time, c);
          hold_errors++;
        end
      end
      if (beat.valid === 1'b1 && data_ready[c]) begin
        check_beat(c, beat);
        beats_got[c]++;
      end
      held[c] = (beat.valid === 1'b1) && !data_ready[c];
      held_data[c] = beat.data;
    end
    drive_ready();
  endtask

  task automatic check_valid(logic expected);
    for (int c = 0; c < CHANNELS; c++) begin
      a_valid: assert (seen_valid[c] === expected) else begin
        $display("[FAIL] %0t: channel %0d out valid is %b, expected %b",
                 $time, c, seen_valid[c], expected);
        valid_errors++;
      end
    end
  endtask

  task automatic write_increments(row_t r);
    stream_pkg::inc_beat_t beat;
    beat = '0;
    beat.valid = 1'b1;
    beat.inc[0] = r.inc0;
    beat.inc[1] = r.inc1;
    phase_inc_in <= beat;
    model_write(0, r.inc0);
    model_write(1, r.inc1);
  endtask

  task automatic run_row(row_t r);
    int target1;
    for (int c = 0; c < CHANNELS; c++) begin
      beats_got[c] = 0;
    end
    // fill and stall every channel before the write
    stall_all = 1'b1;
    repeat (6) step_cycle();
    write_increments(r);
    stall_all = 1'b0;
    ready_mode = r.mode;
    step_cycle();
    phase_inc_in <= '0;
    target1 = (r.mode == READY_CH1_LOW) ? 0 : int'(r.beats);
    while (beats_got[0] < int'(r.beats) || beats_got[1] < target1) begin
      step_cycle();
    end
  endtask

  initial begin : watchdog
    int limit;
    limit = timeout_cycles();
    cycle_count = 0;
    while (cycle_count < limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    $timeformat(-9, 0, " ns", 0);
    reset = 1'b1;
    phase_inc_in = '0;
    data_ready = '1;
    ready_mode = READY_ALWAYS;
    stall_all = 1'b0;
    sample_errors = 0;
    valid_errors = 0;
    hold_errors = 0;
    for (int c = 0; c < CHANNELS; c++) begin
      model_phase[c] = '0;
      model_inc[c] = '0;
      model_next_inc[c] = '0;
      old_steps[c] = 0;
      beats_got[c] = 0;
      held[c] = 1'b0;
    end

    // outputs are unknown before the first reset edge
    step_cycle();
    repeat (2) begin
      step_cycle();
      check_valid(1'b0);
    end
    reset <= 1'b0;
    repeat (3) begin
      step_cycle();
      check_valid(1'b0);
    end
    step_cycle();
    check_valid(1'b1);

    // phase 0 with a zero increment, so every lane is full scale
    repeat (4) step_cycle();

    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(rows[r]);
    end
    repeat (2) step_cycle();

    $display("errors: %0d sample, %0d valid, %0d hold",
             sample_errors, valid_errors, hold_errors);
    if (sample_errors + valid_errors + hold_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
